//--- common/str_link_pkg.sv
// ----------------------------------------
// string link constants and types
// line timing, frame characters and the
// string buffer struct shared by all blocks
// ----------------------------------------

package str_link_pkg;

	// system clock and line rate
	localparam int CLK_FREQ     = 50_000_000;
	localparam int BAUD_RATE    = 115_200;

	// 434 clocks per bit at these rates
	localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;

	// width of the bit-time counters in the uart blocks
	localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

	// string capacity, 128 chars = 1024 bits
	localparam int MAX_CHARS    = 128;
	localparam int LEN_W        = 8;

	// deframer gives up on a frame after 1 ms of silence
	localparam int RX_IDLE_CLKS = 50_000;
	localparam int IDLE_CNT_W   = $clog2(RX_IDLE_CLKS + 1);

	// frame is {{ content }}
	localparam logic [7:0] SOF_CHAR = 8'h7b;
	localparam logic [7:0] EOF_CHAR = 8'h7d;

	// char 0 sits in the lowest byte of chars
	typedef struct packed {
		logic [MAX_CHARS-1:0][7:0] chars;
		logic [LEN_W-1:0]          len;
	} str_buf_t;

endpackage

//--- uart/uart_tx.sv
// ----------------------------------------
// uart transmitter, 8n1
// start bit, 8 data bits lsb first, stop bit
// ----------------------------------------

`timescale 1ns/1ps

module uart_tx
	import str_link_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] byte_data,
	input  logic       byte_req,
	output logic       txd,
	output logic       byte_done
);

	logic                 busy;
	logic [BIT_CNT_W-1:0] clk_cnt;
	logic [3:0]           bit_idx;
	logic [9:0]           tx_shift;
	logic                 bit_end;

	assign bit_end   = (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

	// last cycle of the stop bit
	assign byte_done = busy && bit_end && (bit_idx == 4'd9);

	// shifter fills with ones, so the line idles high
	assign txd       = tx_shift[0];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy     <= 1'b0;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			tx_shift <= '1;
		end else if (!busy) begin
			clk_cnt <= '0;
			bit_idx <= '0;
			if (byte_req) begin
				busy     <= 1'b1;
				// stop, data, start
				tx_shift <= {1'b1, byte_data, 1'b0};
			end
		end else if (bit_end) begin
			clk_cnt  <= '0;
			tx_shift <= {1'b1, tx_shift[9:1]};
			if (bit_idx == 4'd9) begin
				busy <= 1'b0;
			end else begin
				bit_idx <= bit_idx + 4'd1;
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

endmodule

//--- uart/uart_rx.sv
// ----------------------------------------
// uart receiver, 8n1
// two-flop sync, start check at mid-bit,
// mid-bit data sampling, stop bit check
// ----------------------------------------

`timescale 1ns/1ps

module uart_rx
	import str_link_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rxd,
	output logic [7:0] rx_byte,
	output logic       rx_vld
);

	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

	rx_state_t            state;
	logic                 rxd_meta;
	logic                 rxd_sync;
	logic                 rxd_prev;
	logic [BIT_CNT_W-1:0] clk_cnt;
	logic [2:0]           bit_idx;
	logic                 fall;
	logic                 half_bit;
	logic                 full_bit;

	assign fall     = rxd_prev && !rxd_sync;
	assign half_bit = (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT / 2 - 1));
	assign full_bit = (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

	// synchronizer and edge history
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= rx_idle;
			clk_cnt <= '0;
			bit_idx <= '0;
			rx_vld  <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			case (state)
				rx_idle: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (fall) state <= rx_start;
				end
				rx_start: begin
					// still low at mid start bit, else a glitch
					if (half_bit) begin
						clk_cnt <= '0;
						state   <= rxd_sync ? rx_idle : rx_data;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				rx_data: begin
					if (full_bit) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) state <= rx_stop;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				rx_stop: begin
					if (full_bit) begin
						// framing error drops the byte silently
						rx_vld  <= rxd_sync;
						clk_cnt <= '0;
						state   <= rx_idle;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// data bits arrive lsb first
	always_ff @(posedge sys_clk) begin
		if (state == rx_data && full_bit) rx_byte <= {rxd_sync, rx_byte[7:1]};
	end

endmodule

//--- verilog/frame_tx.sv
// ----------------------------------------
// string framer
// sends {{, the string chars and }} as
// back to back bytes through uart_tx
// ----------------------------------------

`timescale 1ns/1ps

module frame_tx
	import str_link_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  str_buf_t   tx_msg,
	input  logic       tx_req,
	output logic       tx_busy,
	output logic       tx_done,
	output logic [7:0] byte_data,
	output logic       byte_req,
	input  logic       byte_done
);

	typedef enum logic [6:0] {
		st_idle   = 7'b000_0001,
		st_sof1   = 7'b000_0010,
		st_sof2   = 7'b000_0100,
		st_body   = 7'b000_1000,
		st_eof1   = 7'b001_0000,
		st_eof2   = 7'b010_0000,
		st_finish = 7'b100_0000
	} tx_state_t;

	tx_state_t        state;
	str_buf_t         msg_q;
	logic [LEN_W-1:0] tx_idx;
	logic             accept;

	// empty strings are not sent
	assign accept  = (state == st_idle) && tx_req && (tx_msg.len != '0);
	assign tx_busy = (state != st_idle);
	assign tx_done = (state == st_finish);

	always_ff @(posedge sys_clk) begin
		if (accept) msg_q <= tx_msg;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:   if (accept) state <= st_sof1;
				st_sof1:   if (byte_done) state <= st_sof2;
				st_sof2:   if (byte_done) state <= st_body;
				st_body:   if (byte_done && tx_idx == msg_q.len) state <= st_eof1;
				st_eof1:   if (byte_done) state <= st_eof2;
				st_eof2:   if (byte_done) state <= st_finish;
				st_finish: state <= st_idle;
				default:   state <= st_idle;
			endcase
		end
	end

	// each byte is requested the cycle after the previous one finished
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			byte_data <= '0;
			byte_req  <= 1'b0;
			tx_idx    <= '0;
		end else begin
			byte_req <= 1'b0;
			case (state)
				st_idle: begin
					tx_idx <= '0;
					if (accept) begin
						byte_data <= SOF_CHAR;
						byte_req  <= 1'b1;
					end
				end
				st_sof1: begin
					if (byte_done) begin
						byte_data <= SOF_CHAR;
						byte_req  <= 1'b1;
					end
				end
				st_sof2: begin
					if (byte_done) begin
						byte_data <= msg_q.chars[0];
						byte_req  <= 1'b1;
						tx_idx    <= LEN_W'(1);
					end
				end
				st_body: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						if (tx_idx != msg_q.len) begin
							byte_data <= msg_q.chars[tx_idx];
							tx_idx    <= tx_idx + 1'b1;
						end else begin
							byte_data <= EOF_CHAR;
						end
					end
				end
				st_eof1: begin
					if (byte_done) begin
						byte_data <= EOF_CHAR;
						byte_req  <= 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

//--- verilog/frame_rx.sv
// ----------------------------------------
// string deframer
// strips {{ and }}, assembles the chars,
// drops a frame after an idle timeout
// ----------------------------------------

`timescale 1ns/1ps

module frame_rx
	import str_link_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] rx_byte,
	input  logic       rx_vld,
	output str_buf_t   rx_msg,
	output logic       rx_busy,
	output logic       rx_done
);

	typedef enum logic [6:0] {
		st_idle   = 7'b000_0001,
		st_sof1   = 7'b000_0010,
		st_sof2   = 7'b000_0100,
		st_body   = 7'b000_1000,
		st_eof1   = 7'b001_0000,
		st_eof2   = 7'b010_0000,
		st_finish = 7'b100_0000
	} rx_state_t;

	rx_state_t                 state;
	logic [MAX_CHARS-1:0][7:0] rx_chars;
	logic [LEN_W-1:0]          rx_len;
	logic [IDLE_CNT_W-1:0]     idle_cnt;
	logic                      timeout;
	logic                      is_sof;
	logic                      is_eof;
	logic                      is_char;
	logic                      room1;
	logic                      room2;
	logic                      store_one;
	logic                      store_pair;

	assign is_sof  = rx_vld && (rx_byte == SOF_CHAR);
	assign is_eof  = rx_vld && (rx_byte == EOF_CHAR);
	assign is_char = rx_vld && (rx_byte != EOF_CHAR);

	// free slots left for one or two more chars
	assign room1 = (rx_len < LEN_W'(MAX_CHARS));
	assign room2 = (rx_len < LEN_W'(MAX_CHARS - 1));

	// a lone } inside the content is kept along with the byte after it
	assign store_one  = (state == st_body) && is_char;
	assign store_pair = (state == st_eof1) && is_char;

	assign timeout = (state != st_idle) && !rx_vld &&
		(idle_cnt == IDLE_CNT_W'(RX_IDLE_CLKS - 1));

	assign rx_busy = (state != st_idle);
	assign rx_done = (state == st_finish);
	assign rx_msg  = '{chars: rx_chars, len: rx_len};

	// silence counter, restarted by every byte
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) idle_cnt <= '0;
		else if (state == st_idle || rx_vld) idle_cnt <= '0;
		else idle_cnt <= idle_cnt + 1'b1;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= st_idle;
		end else if (timeout) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:   if (is_sof) state <= st_sof1;
				// other bytes between the two opening braces are ignored
				st_sof1:   if (is_sof) state <= st_sof2;
				st_sof2:   state <= st_body;
				st_body:   if (is_eof) state <= st_eof1;
				st_eof1: begin
					if (is_eof) state <= st_eof2;
					else if (rx_vld) state <= st_body;
				end
				st_eof2:   state <= st_finish;
				st_finish: state <= st_idle;
				default:   state <= st_idle;
			endcase
		end
	end

	// length saturates at capacity, extra chars are discarded
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_len <= '0;
		end else if (state == st_sof2) begin
			rx_len <= '0;
		end else if (store_one && room1) begin
			rx_len <= rx_len + LEN_W'(1);
		end else if (store_pair && room2) begin
			rx_len <= rx_len + LEN_W'(2);
		end else if (store_pair && room1) begin
			rx_len <= rx_len + LEN_W'(1);
		end
	end

	always_ff @(posedge sys_clk) begin
		if (store_one && room1) rx_chars[rx_len] <= rx_byte;
		if (store_pair && room1) rx_chars[rx_len] <= EOF_CHAR;
		if (store_pair && room2) rx_chars[rx_len + LEN_W'(1)] <= rx_byte;
	end

endmodule

//--- verilog/str_link_top.sv
// ----------------------------------------
// string link top level
// framer and uart_tx on the send side,
// uart_rx and deframer on the receive side
// ----------------------------------------

`timescale 1ns/1ps

module str_link_top
	import str_link_pkg::*;
(
	input  logic     sys_clk,
	input  logic     sys_rst_n,
	input  str_buf_t tx_msg,
	input  logic     tx_req,
	output logic     tx_busy,
	output logic     tx_done,
	output str_buf_t rx_msg,
	output logic     rx_busy,
	output logic     rx_done,
	input  logic     uart_rxd,
	output logic     uart_txd
);

	logic [7:0] byte_data;
	logic       byte_req;
	logic       byte_done;
	logic [7:0] rx_byte;
	logic       rx_vld;

	frame_tx i_frame_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_msg    (tx_msg),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.byte_done (byte_done)
	);

	uart_tx i_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.txd       (uart_txd),
		.byte_done (byte_done)
	);

	// receive path runs independently of the send path
	uart_rx i_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rxd       (uart_rxd),
		.rx_byte   (rx_byte),
		.rx_vld    (rx_vld)
	);

	frame_rx i_frame_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (rx_byte),
		.rx_vld    (rx_vld),
		.rx_msg    (rx_msg),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done)
	);

endmodule

//--- verification/tb_str_link.sv
// ----------------------------------------
// string link testbench
// table of loopback and driven line tests,
// done pulse counters and a watchdog
// ----------------------------------------

`timescale 1ns/1ps

module tb_str_link
	import str_link_pkg::*;
();

	localparam int N_ROWS    = 9;
	localparam int M_LOOP    = 0;
	localparam int M_ZERO    = 1;
	localparam int M_BUSY    = 2;
	localparam int M_DRIVE   = 3;
	localparam int M_IDLE    = 4;
	localparam int BYTE_CLKS = 10 * CLKS_PER_BIT;

	logic     sys_clk;
	logic     sys_rst_n;
	str_buf_t tx_msg;
	logic     tx_req;
	logic     tx_busy;
	logic     tx_done;
	str_buf_t rx_msg;
	logic     rx_busy;
	logic     rx_done;
	logic     uart_rxd;
	logic     uart_txd;

	// 0 selects loopback and 1 the driven line
	logic     line_sel;
	logic     drv_line;

	// one row of stimulus and expected values per test
	int    tbl_mode     [N_ROWS];
	string tbl_str      [N_ROWS];
	int    tbl_len      [N_ROWS];
	string tbl_exp_str  [N_ROWS];
	int    tbl_exp_len  [N_ROWS];
	bit    tbl_exp_done [N_ROWS];

	int     tx_done_cnt;
	int     rx_done_cnt;
	int     err_cnt;
	int     row_err;
	integer seed;
	longint wd_ns;

	assign uart_rxd = line_sel ? drv_line : uart_txd;

	str_link_top i_str_link_top (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_msg    (tx_msg),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.rx_msg    (rx_msg),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.uart_rxd  (uart_rxd),
		.uart_txd  (uart_txd)
	);

	always #10 sys_clk = ~sys_clk;

	// done pulse counters
	always @(posedge sys_clk) begin
		if (tx_done) tx_done_cnt <= tx_done_cnt + 1;
		if (rx_done) rx_done_cnt <= rx_done_cnt + 1;
	end

	task automatic set_row(input int r, input int mode, input string s, input int n,
		input string exp_s, input int exp_n, input bit exp_done);
		tbl_mode[r]     = mode;
		tbl_str[r]      = s;
		tbl_len[r]      = n;
		tbl_exp_str[r]  = exp_s;
		tbl_exp_len[r]  = exp_n;
		tbl_exp_done[r] = exp_done;
	endtask

	function automatic str_buf_t make_msg(input string s, input int n);
		str_buf_t m;
		m = '0;
		for (int i = 0; i < n; i++) begin
			m.chars[i] = s.getc(i);
		end
		m.len = LEN_W'(n);
		return m;
	endfunction

	task automatic check_val(input string name, input int got, input int exp);
		assert (got == exp) else begin
			$display("ERR t=%0t %s expected %0d got %0d", $time, name, exp, got);
			err_cnt++;
			row_err++;
		end
	endtask

	task automatic request(input str_buf_t m);
		@(posedge sys_clk);
		tx_msg <= m;
		tx_req <= 1'b1;
		@(posedge sys_clk);
		tx_req <= 1'b0;
	endtask

	// one 8n1 byte on the driven line
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge sys_clk);
			drv_line <= bits[i];
			repeat (CLKS_PER_BIT - 1) @(posedge sys_clk);
		end
	endtask

	task automatic send_frame(input string s, input int n, input bit close);
		send_byte(SOF_CHAR);
		send_byte(SOF_CHAR);
		for (int i = 0; i < n; i++) begin
			send_byte(s.getc(i));
		end
		if (close) begin
			send_byte(EOF_CHAR);
			send_byte(EOF_CHAR);
		end
	endtask

	task automatic wait_rx_done(input int base, input int limit);
		int n;
		n = 0;
		while (rx_done_cnt == base && n < limit) begin
			@(negedge sys_clk);
			n++;
		end
		assert (rx_done_cnt != base) else begin
			$display("rx_done did not arrive within %0d cycles", limit);
			err_cnt++;
			row_err++;
		end
	endtask

	task automatic wait_tx_idle(input int limit);
		int n;
		n = 0;
		while (tx_busy && n < limit) begin
			@(negedge sys_clk);
			n++;
		end
		assert (!tx_busy) else begin
			$display("tx_busy still high after %0d cycles", limit);
			err_cnt++;
			row_err++;
		end
	endtask

	task automatic run_row(input int r);
		int    tx_base;
		int    rx_base;
		int    limit;
		bit    busy_seen;
		string exp_s;
		row_err   = 0;
		busy_seen = 0;
		exp_s     = tbl_exp_str[r];
		limit     = (tbl_len[r] + 6) * BYTE_CLKS;
		@(negedge sys_clk);
		tx_base = tx_done_cnt;
		rx_base = rx_done_cnt;
		@(posedge sys_clk);
		line_sel <= (tbl_mode[r] == M_DRIVE || tbl_mode[r] == M_IDLE);
		case (tbl_mode[r])
			M_LOOP: begin
				request(make_msg(tbl_str[r], tbl_len[r]));
				wait_rx_done(rx_base, limit);
				wait_tx_idle(limit);
			end
			M_ZERO: begin
				request(make_msg("", 0));
				repeat (BYTE_CLKS) begin
					@(negedge sys_clk);
					if (tx_busy) busy_seen = 1;
				end
				check_val("tx_busy", busy_seen, 0);
			end
			M_BUSY: begin
				request(make_msg(tbl_str[r], tbl_len[r]));
				repeat (3 * BYTE_CLKS) @(posedge sys_clk);
				// second request lands while the first frame is in flight
				@(negedge sys_clk);
				check_val("tx_busy", tx_busy, 1);
				request(make_msg("zz", 2));
				wait_rx_done(rx_base, limit);
				wait_tx_idle(limit);
			end
			M_DRIVE: begin
				send_byte("x");
				send_byte("y");
				send_frame(tbl_str[r], tbl_len[r], 1'b1);
				wait_rx_done(rx_base, 4 * CLKS_PER_BIT);
				repeat (2) @(negedge sys_clk);
				check_val("rx_busy", rx_busy, 0);
			end
			default: begin
				// header and content followed by silence past the idle limit
				send_frame(tbl_str[r], tbl_len[r], 1'b0);
				repeat (RX_IDLE_CLKS + 2 * CLKS_PER_BIT) @(posedge sys_clk);
				@(negedge sys_clk);
				check_val("rx_busy", rx_busy, 0);
			end
		endcase
		@(negedge sys_clk);
		check_val("rx_done pulses", rx_done_cnt - rx_base, tbl_exp_done[r]);
		check_val("tx_done pulses", tx_done_cnt - tx_base,
			(tbl_mode[r] == M_LOOP || tbl_mode[r] == M_BUSY) ? 1 : 0);
		if (tbl_exp_done[r]) begin
			check_val("rx_msg.len", rx_msg.len, tbl_exp_len[r]);
			for (int i = 0; i < tbl_exp_len[r]; i++) begin
				check_val($sformatf("rx_msg.chars[%0d]", i), rx_msg.chars[i], exp_s.getc(i));
			end
		end
		$display("test %0d mode %0d \"%s\" %s", r, tbl_mode[r], tbl_str[r],
			(row_err == 0) ? "ok" : "failed");
	endtask

	initial begin
		wait (wd_ns != 0);
		#(wd_ns);
		$display("watchdog expired after %0d ns, run stopped", wd_ns);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		string       rnd;
		logic [31:0] r;
		sys_clk   = 1'b0;
		sys_rst_n = 1'b0;
		tx_msg    = '0;
		tx_req    = 1'b0;
		line_sel  = 1'b0;
		drv_line  = 1'b1;
		err_cnt   = 0;
		row_err   = 0;
		seed      = 32'hdf4fbc93;

		// random lower case filler that is never a brace
		rnd = "0123456789012345678901234567890123456789";
		for (int i = 0; i < 40; i++) begin
			r = $random(seed);
			rnd.putc(i, 8'h61 + 8'(r[7:0] % 26));
		end

		set_row(0, M_LOOP,  "hello world", 11, "hello world", 11, 1);
		set_row(1, M_LOOP,  "Z", 1, "Z", 1, 1);
		set_row(2, M_LOOP,  rnd, 40, rnd, 40, 1);
		set_row(3, M_LOOP,  "a}b", 3, "a}b", 3, 1);
		set_row(4, M_ZERO,  "", 0, "", 0, 0);
		set_row(5, M_BUSY,  "first", 5, "first", 5, 1);
		set_row(6, M_DRIVE, "frame", 5, "frame", 5, 1);
		set_row(7, M_IDLE,  "ab", 2, "", 0, 0);
		set_row(8, M_DRIVE, "ok", 2, "ok", 2, 1);

		// twice the frame time of every row plus the idle limit
		wd_ns = 0;
		for (int i = 0; i < N_ROWS; i++) begin
			wd_ns += longint'(tbl_len[i] + 4) * BYTE_CLKS * 20;
		end
		wd_ns = (wd_ns + longint'(RX_IDLE_CLKS) * 20) * 2;

		tx_done_cnt = 0;
		rx_done_cnt = 0;
		repeat (5) @(posedge sys_clk);
		sys_rst_n <= 1'b1;

		@(negedge sys_clk);
		check_val("tx_busy", tx_busy, 0);
		check_val("tx_done", tx_done, 0);
		check_val("rx_busy", rx_busy, 0);
		check_val("rx_done", rx_done, 0);
		check_val("uart_txd", uart_txd, 1);

		for (int i = 0; i < N_ROWS; i++) begin
			run_row(i);
		end

		$display("%0d tests run, %0d errors", N_ROWS, err_cnt);
		if (err_cnt == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- sources.f
common/str_link_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
verilog/frame_tx.sv
verilog/frame_rx.sv
verilog/str_link_top.sv
verification/tb_str_link.sv
